/* sim.f */
hdl/ucie_engine_pkg.sv
hdl/flit_fifo.sv
hdl/engine_selector.sv
hdl/engine_dispatch.sv
hdl/engine_load_monitor.sv
hdl/engine_collector.sv
hdl/ucie_parallel_engines.sv
tests/tb_parallel_engines.sv

/* Makefile */
# Verilator flow for the parallel protocol-engine front end

VERILATOR ?= verilator
TOP       ?= tb_parallel_engines
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_parallel_engines.sv */
/*
 * Testbench for the parallel engine front end, with four engine models.
 * Checks dispatch choice, load monitoring and end-to-end flit conservation.
 */
module tb_parallel_engines
    import ucie_engine_pkg::*;
();

    localparam int NE         = 4;
    localparam int FLIT_W     = 512;
    localparam int FIFO_DEPTH = 16;
    localparam int PW         = FLIT_W + PROTO_ID_W + VC_W;
    localparam int WAIT_LIMIT = 2000;

    logic                  clk_quarter_rate = 1'b0;
    logic                  rst_n;
    logic                  engines_enable;
    logic [2:0]            num_active_engines;
    logic [LB_MODE_W-1:0]  lb_mode;
    logic [FLIT_W-1:0]     flit_data;
    logic [PROTO_ID_W-1:0] flit_protocol_id;
    logic [VC_W-1:0]       flit_vc;
    logic                  flit_valid;
    logic                  flit_ready;
    logic [FLIT_W-1:0]     engine_data [NE];
    logic [PROTO_ID_W-1:0] engine_protocol_id [NE];
    logic [VC_W-1:0]       engine_vc [NE];
    logic [NE-1:0]         engine_valid;
    logic [NE-1:0]         engine_ready;
    logic [FLIT_W-1:0]     engine_out_data [NE];
    logic [PROTO_ID_W-1:0] engine_out_protocol_id [NE];
    logic [VC_W-1:0]       engine_out_vc [NE];
    logic [NE-1:0]         engine_out_valid;
    logic [NE-1:0]         engine_out_ready;
    logic [FLIT_W-1:0]     flit_out_data;
    logic [PROTO_ID_W-1:0] flit_out_protocol_id;
    logic [VC_W-1:0]       flit_out_vc;
    logic                  flit_out_valid;
    logic                  flit_out_ready;
    logic [WEIGHT_W-1:0]   engine_weights [NE];
    logic [LOAD_W-1:0]     engine_load [NE];
    logic [NE-1:0]         engine_congested;
    logic [COUNT_W-1:0]    engine_flit_count [NE];

    // Stimulus state, shadow model and engine queues
    logic [31:0]        lfsr = 32'd99845;
    logic [NE-1:0]      hold_stall;
    logic               random_stall;
    logic               out_random;
    logic [15:0]        seq;
    logic [PW-1:0]      in_q [$];
    logic [PW-1:0]      eng_q [NE][$];
    logic [PW-1:0]      exp_out [int];
    logic [LOAD_W-1:0]  sh_load [NE];
    logic [COUNT_W-1:0] sh_count [NE];
    int                 rr_ptr;
    int                 col_ptr;
    int                 out_cnt;
    logic               pend_valid;
    int                 pend_eng;
    logic [PW-1:0]      pend_flit;
    int                 errors;
    int                 n_in;
    int                 n_disp;
    int                 n_out;

    ucie_parallel_engines #(.NUM_ENGINES(NE), .FLIT_W(FLIT_W), .FIFO_DEPTH(FIFO_DEPTH)) UUT (.*);

    always #10 clk_quarter_rate = ~clk_quarter_rate;

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Engine transform: data inverted, engine index folded into the top two bits
    function automatic logic [PW-1:0] engine_result(input logic [PW-1:0] f, input int e);
        logic [FLIT_W-1:0] d;
        d = ~f[PW-1 -: FLIT_W];
        d[FLIT_W-1 -: 2] = d[FLIT_W-1 -: 2] ^ 2'(e);
        return {d, f[PROTO_ID_W+VC_W-1:0]};
    endfunction

    // Balancing rule on shadow loads and shadow pointer, -1 when nothing is eligible
    function automatic int expected_engine(input logic [NE-1:0] free);
        logic [NE-1:0] active;
        logic [NE-1:0] calm;
        logic [NE-1:0] elig;
        longint        score;
        longint        best;
        int            pick;
        for (int i = 0; i < NE; i++) begin
            active[i] = (i < int'(num_active_engines)) && free[i];
            calm[i]   = active[i] && (sh_load[i] <= CONGEST_LEVEL);
        end
        elig = (calm != '0) ? calm : active;
        pick = -1;
        best = 0;
        if (lb_mode == LB_WEIGHTED) begin
            for (int i = 0; i < NE; i++) begin
                score = (longint'(sh_load[i]) * 256) / (longint'(engine_weights[i]) + 1);
                if (elig[i] && (pick < 0 || score < best)) begin
                    best = score;
                    pick = i;
                end
            end
        end else begin
            for (int k = NE - 1; k >= 0; k--) begin
                if (elig[(rr_ptr + k) % NE]) begin
                    pick = (rr_ptr + k) % NE;
                end
            end
        end
        return pick;
    endfunction

    task automatic report_mismatch(input string name, input logic [PW-1:0] got,
                                   input logic [PW-1:0] exp);
        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_fault(input string why);
        $display("Error at %0t: %s", $time, why);
        errors++;
    endtask

    task automatic abort_run(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("Errors: %0d, flits in: %0d, dispatched: %0d, flits out: %0d",
                 errors, n_in, n_disp, n_out);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic send_flits(input int n);
        int waited;
        for (int i = 0; i < n; i++) begin
            flit_data        = {(FLIT_W/16){seq}};
            flit_protocol_id = PROTO_ID_W'(rand_bits(PROTO_ID_W));
            flit_vc          = VC_W'(rand_bits(VC_W));
            flit_valid       = 1'b1;
            waited           = 0;
            @(posedge clk_quarter_rate);
            while (!flit_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("input port never became ready");
                end
                @(posedge clk_quarter_rate);
            end
            @(negedge clk_quarter_rate);
            seq++;
        end
        flit_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (in_q.size() > 0 || exp_out.num() > 0 || pend_valid) begin
            @(negedge clk_quarter_rate);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("flits did not drain through the DUT");
            end
        end
    endtask

    // Engine models and output sink, driven on the falling edge
    always @(negedge clk_quarter_rate) begin
        for (int e = 0; e < NE; e++) begin
            if (hold_stall[e]) begin
                engine_ready[e] = 1'b0;
            end else if (random_stall) begin
                engine_ready[e] = (rand_bits(2) != 0);
            end else begin
                engine_ready[e] = 1'b1;
            end
            engine_out_valid[e] = (eng_q[e].size() > 0);
            if (eng_q[e].size() > 0) begin
                {engine_out_data[e], engine_out_protocol_id[e], engine_out_vc[e]} = eng_q[e][0];
            end
        end
        flit_out_ready = out_random ? (rand_bits(1) != 0) : 1'b1;
    end

    // Comparing process, samples the values held before each rising edge
    always @(posedge clk_quarter_rate) begin
        logic [NE-1:0] free;
        logic [NE-1:0] grant;
        logic          granted;
        logic [PW-1:0] got;
        logic [15:0]   key;
        int            pick;
        if (rst_n) begin
            // Flit chosen at the previous edge must now sit in its slot
            if (pend_valid) begin
                got = {engine_data[pend_eng], engine_protocol_id[pend_eng], engine_vc[pend_eng]};
                assert (engine_valid[pend_eng]) else
                    report_fault($sformatf("engine_valid[%0d] low after dispatch", pend_eng));
                assert (got == pend_flit) else
                    report_mismatch($sformatf("engine_data[%0d]", pend_eng), got, pend_flit);
            end
            for (int e = 0; e < NE; e++) begin
                assert (engine_load[e] == sh_load[e]) else
                    report_mismatch($sformatf("engine_load[%0d]", e),
                                    PW'(engine_load[e]), PW'(sh_load[e]));
                assert (engine_congested[e] == (sh_load[e] > CONGEST_LEVEL)) else
                    report_mismatch($sformatf("engine_congested[%0d]", e),
                                    PW'(engine_congested[e]), PW'(sh_load[e] > CONGEST_LEVEL));
                assert (engine_flit_count[e] == sh_count[e]) else
                    report_mismatch($sformatf("engine_flit_count[%0d]", e),
                                    PW'(engine_flit_count[e]), PW'(sh_count[e]));
            end
            assert (flit_ready == (engines_enable && in_q.size() < FIFO_DEPTH)) else
                report_mismatch("flit_ready", PW'(flit_ready),
                                PW'(engines_enable && in_q.size() < FIFO_DEPTH));

            // Collector grant from the shadow pointer, none while the output FIFO is full
            grant   = '0;
            granted = 1'b0;
            if (out_cnt < FIFO_DEPTH) begin
                for (int k = 0; k < NE; k++) begin
                    if (!granted && engine_out_valid[(col_ptr + k) % NE]) begin
                        grant[(col_ptr + k) % NE] = 1'b1;
                        granted = 1'b1;
                    end
                end
            end
            assert (engine_out_ready == grant) else
                report_mismatch("engine_out_ready", PW'(engine_out_ready), PW'(grant));
            assert (flit_out_valid == (out_cnt > 0)) else
                report_mismatch("flit_out_valid", PW'(flit_out_valid), PW'(out_cnt > 0));

            free       = ~engine_valid | engine_ready;
            pend_valid = 1'b0;
            if (in_q.size() > 0) begin
                pick = expected_engine(free);
                if (pick >= 0) begin
                    pend_valid = 1'b1;
                    pend_eng   = pick;
                    pend_flit  = in_q.pop_front();
                    key        = pend_flit[PROTO_ID_W+VC_W +: 16];
                    exp_out[int'(key)] = engine_result(pend_flit, pick);
                    rr_ptr = (pick + 1) % NE;
                    n_disp++;
                end
            end
            if (flit_valid && flit_ready) begin
                in_q.push_back({flit_data, flit_protocol_id, flit_vc});
                n_in++;
            end

            for (int e = 0; e < NE; e++) begin
                if (engine_valid[e] && engine_ready[e]) begin
                    eng_q[e].push_back(engine_result(
                        {engine_data[e], engine_protocol_id[e], engine_vc[e]}, e));
                    sh_count[e]++;
                end
                if (engine_valid[e] && !engine_ready[e]) begin
                    if (sh_load[e] != '1) begin
                        sh_load[e]++;
                    end
                end else if (sh_load[e] != '0) begin
                    sh_load[e]--;
                end
                if (engine_out_valid[e] && engine_out_ready[e]) begin
                    void'(eng_q[e].pop_front());
                    out_cnt++;
                    col_ptr = (e + 1) % NE;
                end
            end

            if (flit_out_valid && flit_out_ready) begin
                got = {flit_out_data, flit_out_protocol_id, flit_out_vc};
                key = ~flit_out_data[15:0];
                n_out++;
                out_cnt--;
                if (exp_out.exists(int'(key))) begin
                    assert (got == exp_out[int'(key)]) else
                        report_mismatch("flit_out_data", got, exp_out[int'(key)]);
                    exp_out.delete(int'(key));
                end else begin
                    report_fault($sformatf("flit %0d left flit_out unexpectedly", key));
                end
            end
        end
    end

    initial begin
        rst_n              = 1'b0;
        engines_enable     = 1'b0;
        num_active_engines = 3'd4;
        lb_mode            = LB_ROUND_ROBIN;
        flit_data          = '0;
        flit_protocol_id   = '0;
        flit_vc            = '0;
        flit_valid         = 1'b0;
        flit_out_ready     = 1'b0;
        engine_ready       = '0;
        engine_out_valid   = '0;
        hold_stall         = '0;
        random_stall       = 1'b0;
        out_random         = 1'b0;
        seq                = '0;
        rr_ptr             = 0;
        col_ptr            = 0;
        out_cnt            = 0;
        pend_valid         = 1'b0;
        errors             = 0;
        n_in               = 0;
        n_disp             = 0;
        n_out              = 0;
        for (int e = 0; e < NE; e++) begin
            engine_out_data[e]        = '0;
            engine_out_protocol_id[e] = '0;
            engine_out_vc[e]          = '0;
            sh_load[e]                = '0;
            sh_count[e]               = '0;
        end
        // Unequal weights for the weighted phase
        engine_weights[0] = 8'd3;
        engine_weights[1] = 8'd1;
        engine_weights[2] = 8'd7;
        engine_weights[3] = 8'd0;
        repeat (16) @(negedge clk_quarter_rate);
        rst_n = 1'b1;

        // Offered flit must be refused while disabled
        flit_valid = 1'b1;
        repeat (8) begin
            @(negedge clk_quarter_rate);
            assert (!flit_ready && engine_valid == '0 && engine_out_ready == '0
                    && !flit_out_valid) else
                report_fault("control outputs active before traffic with engines disabled");
        end
        flit_valid     = 1'b0;
        engines_enable = 1'b1;

        send_flits(24);
        wait_drain();
        num_active_engines = 3'd2;
        send_flits(16);
        wait_drain();

        // Weighted least-load with engine 1 held stalled
        num_active_engines = 3'd4;
        lb_mode            = LB_WEIGHTED;
        random_stall       = 1'b1;
        hold_stall         = 4'b0010;
        send_flits(40);
        hold_stall   = '0;
        random_stall = 1'b0;
        wait_drain();

        // Push engine 2 past the congestion level, then release it under traffic
        lb_mode    = LB_ROUND_ROBIN;
        hold_stall = 4'b0100;
        send_flits(8);
        repeat (220) @(negedge clk_quarter_rate);
        assert (engine_congested[2]) else
            report_fault("engine 2 not congested after a long stall");
        hold_stall = '0;
        send_flits(40);
        wait_drain();

        // Unknown mode code with random stalls and output back-pressure
        lb_mode            = 2'b11;
        num_active_engines = 3'd3;
        random_stall       = 1'b1;
        out_random         = 1'b1;
        send_flits(60);
        random_stall = 1'b0;
        out_random   = 1'b0;
        wait_drain();

        repeat (4) @(negedge clk_quarter_rate);
        assert (n_in == n_out) else
            report_fault("number of flits out differs from flits accepted");
        $display("Errors: %0d, flits in: %0d, dispatched: %0d, flits out: %0d",
                 errors, n_in, n_disp, n_out);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* hdl/ucie_parallel_engines.sv */
/*
 * Front end of the parallel protocol engines: input FIFO, engine selection,
 * per-engine dispatch slots, load monitoring and result collection.
 */
module ucie_parallel_engines
    import ucie_engine_pkg::*;
#(
    parameter int NUM_ENGINES = 4,
    parameter int FLIT_W      = 512,
    parameter int FIFO_DEPTH  = 16
) (
    input  logic                         clk_quarter_rate,
    input  logic                         rst_n,

    // Configuration
    input  logic                         engines_enable,
    input  logic [$clog2(NUM_ENGINES):0] num_active_engines,
    input  logic [LB_MODE_W-1:0]         lb_mode,

    // Wide input port
    input  logic [FLIT_W-1:0]            flit_data,
    input  logic [PROTO_ID_W-1:0]        flit_protocol_id,
    input  logic [VC_W-1:0]              flit_vc,
    input  logic                         flit_valid,
    output logic                         flit_ready,

    // Toward the engines
    output logic [FLIT_W-1:0]            engine_data [NUM_ENGINES],
    output logic [PROTO_ID_W-1:0]        engine_protocol_id [NUM_ENGINES],
    output logic [VC_W-1:0]              engine_vc [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0]       engine_valid,
    input  logic [NUM_ENGINES-1:0]       engine_ready,

    // Results from the engines
    input  logic [FLIT_W-1:0]            engine_out_data [NUM_ENGINES],
    input  logic [PROTO_ID_W-1:0]        engine_out_protocol_id [NUM_ENGINES],
    input  logic [VC_W-1:0]              engine_out_vc [NUM_ENGINES],
    input  logic [NUM_ENGINES-1:0]       engine_out_valid,
    output logic [NUM_ENGINES-1:0]       engine_out_ready,

    // Wide output port
    output logic [FLIT_W-1:0]            flit_out_data,
    output logic [PROTO_ID_W-1:0]        flit_out_protocol_id,
    output logic [VC_W-1:0]              flit_out_vc,
    output logic                         flit_out_valid,
    input  logic                         flit_out_ready,

    // Load balancing
    input  logic [WEIGHT_W-1:0]          engine_weights [NUM_ENGINES],
    output logic [LOAD_W-1:0]            engine_load [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0]       engine_congested,
    output logic [COUNT_W-1:0]           engine_flit_count [NUM_ENGINES]
);

    localparam int PW = FLIT_W + PROTO_ID_W + VC_W;

    logic                           in_full;
    logic [PW-1:0]                  in_head;
    logic                           in_head_valid;
    logic                           in_pop;
    logic [$clog2(NUM_ENGINES)-1:0] selected;
    logic                           select_valid;
    logic [NUM_ENGINES-1:0]         slot_free;
    logic                           out_full;
    logic                           out_push;
    logic [PW-1:0]                  out_push_data;
    logic [PW-1:0]                  out_head;

    assign flit_ready = engines_enable && !in_full;

    flit_fifo #(.FLIT_W(FLIT_W), .FIFO_DEPTH(FIFO_DEPTH)) input_fifo (
        .clk_quarter_rate, .rst_n,
        .push       (flit_valid && flit_ready),
        .push_data  ({flit_data, flit_protocol_id, flit_vc}),
        .pop        (in_pop),
        .head_data  (in_head),
        .head_valid (in_head_valid),
        .full       (in_full)
    );

    engine_selector #(.NUM_ENGINES(NUM_ENGINES)) u_selector (
        .clk_quarter_rate, .rst_n, .lb_mode, .num_active_engines,
        .engine_weights, .engine_load, .engine_congested, .slot_free,
        .head_valid   (in_head_valid),
        .advance      (in_pop),
        .selected     (selected),
        .select_valid (select_valid)
    );

    engine_dispatch #(.NUM_ENGINES(NUM_ENGINES), .FLIT_W(FLIT_W)) u_dispatch (
        .clk_quarter_rate, .rst_n,
        .head_data    (in_head),
        .head_valid   (in_head_valid),
        .selected     (selected),
        .select_valid (select_valid),
        .engine_ready, .engine_data, .engine_protocol_id, .engine_vc,
        .engine_valid, .slot_free,
        .pop          (in_pop)
    );

    engine_load_monitor #(.NUM_ENGINES(NUM_ENGINES)) u_load_monitor (
        .clk_quarter_rate, .rst_n, .engine_valid, .engine_ready,
        .engine_load, .engine_congested, .engine_flit_count
    );

    engine_collector #(.NUM_ENGINES(NUM_ENGINES), .FLIT_W(FLIT_W)) u_collector (
        .clk_quarter_rate, .rst_n, .engine_out_data, .engine_out_protocol_id,
        .engine_out_vc, .engine_out_valid, .engine_out_ready,
        .out_full  (out_full),
        .push      (out_push),
        .push_data (out_push_data)
    );

    flit_fifo #(.FLIT_W(FLIT_W), .FIFO_DEPTH(FIFO_DEPTH)) output_fifo (
        .clk_quarter_rate, .rst_n,
        .push       (out_push),
        .push_data  (out_push_data),
        .pop        (flit_out_ready),
        .head_data  (out_head),
        .head_valid (flit_out_valid),
        .full       (out_full)
    );

    assign {flit_out_data, flit_out_protocol_id, flit_out_vc} = out_head;

endmodule

/* hdl/engine_collector.sv */
/*
 * Round-robin arbiter returning engine results to the output FIFO.
 * Grants at most one engine per cycle and none while the FIFO is full.
 */
module engine_collector
    import ucie_engine_pkg::*;
#(
    parameter int NUM_ENGINES = 4,
    parameter int FLIT_W      = 512
) (
    input  logic                              clk_quarter_rate,
    input  logic                              rst_n,
    input  logic [FLIT_W-1:0]                 engine_out_data [NUM_ENGINES],
    input  logic [PROTO_ID_W-1:0]             engine_out_protocol_id [NUM_ENGINES],
    input  logic [VC_W-1:0]                   engine_out_vc [NUM_ENGINES],
    input  logic [NUM_ENGINES-1:0]            engine_out_valid,
    input  logic                              out_full,
    output logic [NUM_ENGINES-1:0]            engine_out_ready,
    output logic                              push,
    output logic [FLIT_W+PROTO_ID_W+VC_W-1:0] push_data
);

    localparam int IDX_W = $clog2(NUM_ENGINES);

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] grant_idx;

    always_comb begin
        logic             found;
        logic [IDX_W-1:0] idx;
        found     = 1'b0;
        grant_idx = rr_ptr;
        for (int k = 0; k < NUM_ENGINES; k++) begin
            idx = IDX_W'((rr_ptr + k) % NUM_ENGINES);
            if (!found && engine_out_valid[idx]) begin
                grant_idx = idx;
                found     = 1'b1;
            end
        end
        push = found && !out_full;
        // One-hot ready toward the granted engine
        engine_out_ready            = '0;
        engine_out_ready[grant_idx] = push;
        push_data = {engine_out_data[grant_idx],
                     engine_out_protocol_id[grant_idx],
                     engine_out_vc[grant_idx]};
    end

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (push) begin
            rr_ptr <= (grant_idx == IDX_W'(NUM_ENGINES - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

endmodule

/* hdl/engine_load_monitor.sv */
/*
 * Tracks stall-driven load, congestion and dispatched flits per engine.
 * Watches the outbound valid/ready pairs only.
 */
module engine_load_monitor
    import ucie_engine_pkg::*;
#(
    parameter int NUM_ENGINES = 4
) (
    input  logic                   clk_quarter_rate,
    input  logic                   rst_n,
    input  logic [NUM_ENGINES-1:0] engine_valid,
    input  logic [NUM_ENGINES-1:0] engine_ready,
    output logic [LOAD_W-1:0]      engine_load [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0] engine_congested,
    output logic [COUNT_W-1:0]     engine_flit_count [NUM_ENGINES]
);

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ENGINES; i++) begin
                engine_load[i]       <= '0;
                engine_flit_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENGINES; i++) begin
                // Stalled slot adds load, anything else drains it
                if (engine_valid[i] && !engine_ready[i]) begin
                    if (engine_load[i] != '1) begin
                        engine_load[i] <= engine_load[i] + 1'b1;
                    end
                end else if (engine_load[i] != '0) begin
                    engine_load[i] <= engine_load[i] - 1'b1;
                end
                if (engine_valid[i] && engine_ready[i]) begin
                    engine_flit_count[i] <= engine_flit_count[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            engine_congested[i] = (engine_load[i] > CONGEST_LEVEL);
        end
    end

endmodule

/* hdl/engine_dispatch.sv */
/*
 * One registered valid/ready output slot per engine.
 * Loads the selected slot from the input FIFO head and pops the FIFO.
 */
module engine_dispatch
    import ucie_engine_pkg::*;
#(
    parameter int NUM_ENGINES = 4,
    parameter int FLIT_W      = 512
) (
    input  logic                              clk_quarter_rate,
    input  logic                              rst_n,
    input  logic [FLIT_W+PROTO_ID_W+VC_W-1:0] head_data,
    input  logic                              head_valid,
    input  logic [$clog2(NUM_ENGINES)-1:0]    selected,
    input  logic                              select_valid,
    input  logic [NUM_ENGINES-1:0]            engine_ready,
    output logic [FLIT_W-1:0]                 engine_data [NUM_ENGINES],
    output logic [PROTO_ID_W-1:0]             engine_protocol_id [NUM_ENGINES],
    output logic [VC_W-1:0]                   engine_vc [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0]            engine_valid,
    output logic [NUM_ENGINES-1:0]            slot_free,
    output logic                              pop
);

    // Empty slot, or one whose flit leaves this cycle
    assign slot_free = ~engine_valid | engine_ready;
    assign pop       = head_valid && select_valid;

    always_ff @(posedge clk_quarter_rate) begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            if (pop && (selected == i)) begin
                {engine_data[i], engine_protocol_id[i], engine_vc[i]} <= head_data;
            end
        end
    end

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            engine_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_ENGINES; i++) begin
                if (pop && (selected == i)) begin
                    engine_valid[i] <= 1'b1;
                end else if (engine_ready[i]) begin
                    engine_valid[i] <= 1'b0;
                end
            end
        end
    end

endmodule

/* hdl/engine_selector.sv */
/*
 * Picks the target engine for the flit at the input FIFO head.
 * Round-robin or weighted least-load, steering clear of congested engines.
 */
module engine_selector
    import ucie_engine_pkg::*;
#(
    parameter int NUM_ENGINES = 4
) (
    input  logic                           clk_quarter_rate,
    input  logic                           rst_n,
    input  logic [LB_MODE_W-1:0]           lb_mode,
    input  logic [$clog2(NUM_ENGINES):0]   num_active_engines,
    input  logic [WEIGHT_W-1:0]            engine_weights [NUM_ENGINES],
    input  logic [LOAD_W-1:0]              engine_load [NUM_ENGINES],
    input  logic [NUM_ENGINES-1:0]         engine_congested,
    input  logic [NUM_ENGINES-1:0]         slot_free,
    input  logic                           head_valid,
    input  logic                           advance,
    output logic [$clog2(NUM_ENGINES)-1:0] selected,
    output logic                           select_valid
);

    localparam int IDX_W   = $clog2(NUM_ENGINES);
    localparam int SCORE_W = LOAD_W + 8;

    logic [NUM_ENGINES-1:0] active;
    logic [NUM_ENGINES-1:0] calm;
    logic [NUM_ENGINES-1:0] eligible;
    logic [IDX_W-1:0]       rr_ptr;
    logic [IDX_W-1:0]       rr_pick;
    logic [IDX_W-1:0]       wt_pick;

    always_comb begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            active[i] = (i < num_active_engines) && slot_free[i];
        end
        calm = active & ~engine_congested;
        // Fall back to congested engines only when nothing else is free
        eligible = (|calm) ? calm : active;
    end

    // First eligible engine at or after the pointer
    always_comb begin
        logic             found;
        logic [IDX_W-1:0] idx;
        found   = 1'b0;
        rr_pick = rr_ptr;
        for (int k = 0; k < NUM_ENGINES; k++) begin
            idx = IDX_W'((rr_ptr + k) % NUM_ENGINES);
            if (!found && eligible[idx]) begin
                rr_pick = idx;
                found   = 1'b1;
            end
        end
    end

    // Lowest load*256/(weight+1), ties go to the lower index
    always_comb begin
        logic [SCORE_W-1:0] score;
        logic [SCORE_W-1:0] best;
        logic               found;
        found   = 1'b0;
        best    = '1;
        wt_pick = '0;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            score = {engine_load[i], 8'd0} / (SCORE_W'(engine_weights[i]) + 1'b1);
            if (eligible[i] && (!found || score < best)) begin
                best    = score;
                wt_pick = IDX_W'(i);
                found   = 1'b1;
            end
        end
    end

    assign selected     = (lb_mode == LB_WEIGHTED) ? wt_pick : rr_pick;
    assign select_valid = head_valid && (|eligible);

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (advance) begin
            rr_ptr <= (selected == IDX_W'(NUM_ENGINES - 1)) ? '0 : selected + 1'b1;
        end
    end

endmodule

/* hdl/flit_fifo.sv */
/*
 * First-word-fall-through FIFO holding a flit plus its protocol id and VC.
 * Serves as both the input buffer and the output buffer of the front end.
 */
module flit_fifo
    import ucie_engine_pkg::*;
#(
    parameter int FLIT_W     = 512,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                             clk_quarter_rate,
    input  logic                             rst_n,
    input  logic                             push,
    input  logic [FLIT_W+PROTO_ID_W+VC_W-1:0] push_data,
    input  logic                             pop,
    output logic [FLIT_W+PROTO_ID_W+VC_W-1:0] head_data,
    output logic                             head_valid,
    output logic                             full
);

    localparam int PW = FLIT_W + PROTO_ID_W + VC_W;
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [PW-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && head_valid;

    always_ff @(posedge clk_quarter_rate) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_data  = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign full       = (count == (AW+1)'(FIFO_DEPTH));

endmodule

/* hdl/ucie_engine_pkg.sv */
/*
 * Shared constants for the parallel protocol-engine front end.
 * Imported by every RTL module of the engine datapath.
 */
package ucie_engine_pkg;

    // Balancing mode codes, any other code behaves as round-robin
    localparam int                   LB_MODE_W      = 2;
    localparam logic [LB_MODE_W-1:0] LB_ROUND_ROBIN = 2'b00;
    localparam logic [LB_MODE_W-1:0] LB_WEIGHTED    = 2'b01;

    // Flit sideband fields
    localparam int PROTO_ID_W = 4;
    localparam int VC_W       = 8;

    // Load balancing
    localparam int                LOAD_W        = 16;
    localparam int                WEIGHT_W      = 8;
    localparam logic [LOAD_W-1:0] CONGEST_LEVEL = LOAD_W'(192);

    // Per-engine statistics
    localparam int COUNT_W = 16;

endpackage
